/* design/sa_cfg_pkg.sv */
package sa_cfg_pkg;

  // array geometry
  // lanes across, and one accumulate stage per lane going down
  localparam int LANES = 4;

  // activation and weight element width, unsigned
  localparam int ELEM_W = 8;

  // partial sum width
  // all sums wrap modulo 2^PSUM_W
  localparam int PSUM_W = 16;

  // one vector register worth of 8-bit elements
  // element i sits at [i], lane 0 in the low byte
  typedef logic [LANES-1:0][ELEM_W-1:0] act_vec_t;

  // one vector register worth of 16-bit partial sums
  // lane j sits at [j], lane 0 in the low half-word
  typedef logic [LANES-1:0][PSUM_W-1:0] psum_vec_t;

endpackage

/* design/gsau_cmd_pkg.sv */
package gsau_cmd_pkg;

  // destination register tag width
  // matches the scoreboard vdst field
  localparam int TAG_W = 8;

  // tag fifo entries
  // must stay above the LANES+1 results that can be
  // between issue and the writeback register
  localparam int TAG_DEPTH = 8;

  // destination tag of one compute command
  typedef logic [TAG_W-1:0] tag_t;

endpackage

/* design/gsau_ifs.sv */
// issue side into the systolic array
interface sa_feed_if;
  // activations, or the new top weight row
  sa_cfg_pkg::act_vec_t  data;
  // incoming partial sums of a compute item
  sa_cfg_pkg::psum_vec_t partials;
  // one compute item enters this cycle
  logic                  input_en;
  // shift data into the weight rows this cycle
  logic                  weight_en;
  // pipeline advances on the next edge
  logic                  can_accept;

  modport issue (
    output data, partials, input_en, weight_en,
    input  can_accept
  );

  modport array (
    input  data, partials, input_en, weight_en,
    output can_accept
  );
endinterface

// destination tag fifo, pushed by issue and popped by writeback
interface tag_if;
  logic               push;
  gsau_cmd_pkg::tag_t push_tag;
  logic               pop;
  logic               full;
  logic               empty;
  // oldest tag, valid when not empty
  gsau_cmd_pkg::tag_t head_tag;

  modport pusher (output push, push_tag, input full, empty);
  modport popper (output pop, input head_tag);
  modport fifo (input push, push_tag, pop, output full, empty, head_tag);
endinterface

// last array stage into the writeback register
interface sa_result_if;
  sa_cfg_pkg::psum_vec_t psum;
  logic                  out_valid;
  // transfer happens on an edge with out_valid and out_ready both high
  logic                  out_ready;

  modport array (output psum, out_valid, input out_ready);
  modport sink (input psum, out_valid, output out_ready);
endinterface

/* design/gsau_issue.sv */
module gsau_issue (
  // scoreboard side
  input  logic                  i_sb_valid,
  input  logic                  i_sb_weight,
  input  gsau_cmd_pkg::tag_t    i_sb_vdst,
  // vector register file side
  input  logic                  i_veg_valid,
  input  sa_cfg_pkg::act_vec_t  i_veg_vs1,
  input  sa_cfg_pkg::psum_vec_t i_veg_vs2,
  // ready back to scoreboard and register file
  output logic                  o_sb_ready,
  // array feed and tag push
  sa_feed_if.issue              feed,
  tag_if.pusher                 tags
);

  logic accept;

  // ready level
  // compute needs a moving pipeline and a free tag slot
  // weight load also waits until nothing is in the array,
  // an empty tag fifo means no compute is still in flight
  always_comb begin
    o_sb_ready = feed.can_accept && !tags.full;
    if (i_sb_weight) begin
      o_sb_ready = o_sb_ready && tags.empty;
    end
  end

  // both sources valid plus our ready
  assign accept = i_sb_valid && i_veg_valid && o_sb_ready;

  // vs1 goes out as weights or activations
  assign feed.data     = i_veg_vs1;
  // vs2 only matters for compute items
  assign feed.partials = i_veg_vs2;

  // one-cycle strobes in the acceptance cycle
  assign feed.weight_en = accept && i_sb_weight;
  assign feed.input_en  = accept && !i_sb_weight;

  // tag goes in together with the compute item
  assign tags.push     = accept && !i_sb_weight;
  assign tags.push_tag = i_sb_vdst;

endmodule

/* design/systolic_array.sv */
module systolic_array (
  input  logic       CLK,
  input  logic       i_reset,
  sa_feed_if.array   feed,
  sa_result_if.array res
);

  // weight rows, row 0 is the most recently loaded
  sa_cfg_pkg::act_vec_t  weight_row [sa_cfg_pkg::LANES];

  // stage 0 holds the raw item, stage LANES is the output stage
  logic                  stage_valid [sa_cfg_pkg::LANES+1];
  sa_cfg_pkg::psum_vec_t stage_psum  [sa_cfg_pkg::LANES+1];
  // activations only needed up to the last accumulate stage
  sa_cfg_pkg::act_vec_t  stage_act   [sa_cfg_pkg::LANES];

  // sums leaving each accumulate stage
  sa_cfg_pkg::psum_vec_t stage_sum   [sa_cfg_pkg::LANES];

  // whole pipeline freezes while a finished result is blocked
  assign feed.can_accept = !stage_valid[sa_cfg_pkg::LANES] || res.out_ready;

  // weight row shift
  // new row enters on top, oldest row falls off the bottom
  always_ff @(posedge CLK) begin
    if (i_reset) begin
      for (int i = 0; i < sa_cfg_pkg::LANES; i++) begin
        weight_row[i] <= '0;
      end
    end else if (feed.weight_en) begin
      weight_row[0] <= feed.data;
      for (int i = 1; i < sa_cfg_pkg::LANES; i++) begin
        weight_row[i] <= weight_row[i-1];
      end
    end
  end

  // accumulate step of stage i
  // lane j gains act element i times row i element j
  // product widens to PSUM_W from the assignment context, sum wraps
  always_comb begin
    for (int i = 0; i < sa_cfg_pkg::LANES; i++) begin
      for (int j = 0; j < sa_cfg_pkg::LANES; j++) begin
        stage_sum[i][j] = stage_psum[i][j] + stage_act[i][i] * weight_row[i][j];
      end
    end
  end

  // stage valid bits
  always_ff @(posedge CLK) begin
    if (i_reset) begin
      for (int i = 0; i <= sa_cfg_pkg::LANES; i++) begin
        stage_valid[i] <= 1'b0;
      end
    end else if (feed.can_accept) begin
      // bubble enters when no item is offered
      stage_valid[0] <= feed.input_en;
      for (int i = 0; i < sa_cfg_pkg::LANES; i++) begin
        stage_valid[i+1] <= stage_valid[i];
      end
    end
  end

  // stage payload, moves in lockstep with the valid bits
  always_ff @(posedge CLK) begin
    if (feed.can_accept) begin
      stage_act[0]  <= feed.data;
      stage_psum[0] <= feed.partials;
      for (int i = 0; i < sa_cfg_pkg::LANES - 1; i++) begin
        stage_act[i+1] <= stage_act[i];
      end
      for (int i = 0; i < sa_cfg_pkg::LANES; i++) begin
        stage_psum[i+1] <= stage_sum[i];
      end
    end
  end

  // output stage
  // valid LANES edges after entry
  assign res.psum      = stage_psum[sa_cfg_pkg::LANES];
  assign res.out_valid = stage_valid[sa_cfg_pkg::LANES];

endmodule

/* design/gsau_tag_fifo.sv */
module gsau_tag_fifo (
  input  logic CLK,
  input  logic i_reset,
  tag_if.fifo  tags
);

  // tag storage, circular
  gsau_cmd_pkg::tag_t mem [gsau_cmd_pkg::TAG_DEPTH];

  logic [$clog2(gsau_cmd_pkg::TAG_DEPTH)-1:0] wr_ptr;
  logic [$clog2(gsau_cmd_pkg::TAG_DEPTH)-1:0] rd_ptr;
  // one extra bit so a full fifo can be counted
  logic [$clog2(gsau_cmd_pkg::TAG_DEPTH):0]   count;

  logic push_ok;
  logic pop_ok;

  // overflow and underflow are dropped here
  assign push_ok = tags.push && !tags.full;
  assign pop_ok  = tags.pop && !tags.empty;

  assign tags.full     = (int'(count) == gsau_cmd_pkg::TAG_DEPTH);
  assign tags.empty    = (count == '0);
  assign tags.head_tag = mem[rd_ptr];

  // tag write
  always_ff @(posedge CLK) begin
    if (push_ok) begin
      mem[wr_ptr] <= tags.push_tag;
    end
  end

  // pointers and fill level
  always_ff @(posedge CLK) begin
    if (i_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok) begin
        // wrap at depth
        wr_ptr <= (int'(wr_ptr) == gsau_cmd_pkg::TAG_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= (int'(rd_ptr) == gsau_cmd_pkg::TAG_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      // same-edge push and pop leaves the level alone
      if (push_ok && !pop_ok) begin
        count <= count + 1'b1;
      end else if (pop_ok && !push_ok) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

/* design/gsau_writeback.sv */
module gsau_writeback (
  input  logic                   CLK,
  input  logic                   i_reset,
  sa_result_if.sink              res,
  tag_if.popper                  tags,
  // writeback buffer side
  input  logic                   i_wb_ready,
  output logic                   o_wb_valid,
  output sa_cfg_pkg::psum_vec_t  o_wb_psum,
  output gsau_cmd_pkg::tag_t     o_wb_dst
);

  logic take;

  // room when empty or when the held result leaves this edge
  assign res.out_ready = !o_wb_valid || i_wb_ready;
  assign take          = res.out_valid && res.out_ready;

  // results leave the array in issue order,
  // so the head tag always belongs to the arriving result
  assign tags.pop = take;

  // output register valid
  always_ff @(posedge CLK) begin
    if (i_reset) begin
      o_wb_valid <= 1'b0;
    end else if (take) begin
      o_wb_valid <= 1'b1;
    end else if (i_wb_ready) begin
      o_wb_valid <= 1'b0;
    end
  end

  // payload only changes on a transfer, stable under back-pressure
  always_ff @(posedge CLK) begin
    if (take) begin
      o_wb_psum <= res.psum;
      o_wb_dst  <= tags.head_tag;
    end
  end

endmodule

/* design/gsau_top.sv */
module gsau_top (
  input  logic                  CLK,
  input  logic                  i_reset,
  // scoreboard
  input  logic                  i_sb_valid,
  input  logic                  i_sb_weight,
  input  gsau_cmd_pkg::tag_t    i_sb_vdst,
  // vector register file
  input  logic                  i_veg_valid,
  input  sa_cfg_pkg::act_vec_t  i_veg_vs1,
  input  sa_cfg_pkg::psum_vec_t i_veg_vs2,
  // shared ready for scoreboard and register file
  output logic                  o_sb_ready,
  // writeback buffer
  input  logic                  i_wb_ready,
  output logic                  o_wb_valid,
  output sa_cfg_pkg::psum_vec_t o_wb_psum,
  output gsau_cmd_pkg::tag_t    o_wb_dst
);

  // internal links
  sa_feed_if   feed_if ();
  tag_if       tag_bus ();
  sa_result_if result_if ();

  // command decode and ready
  gsau_issue u_gsau_issue (
    .i_sb_valid  (i_sb_valid),
    .i_sb_weight (i_sb_weight),
    .i_sb_vdst   (i_sb_vdst),
    .i_veg_valid (i_veg_valid),
    .i_veg_vs1   (i_veg_vs1),
    .i_veg_vs2   (i_veg_vs2),
    .o_sb_ready  (o_sb_ready),
    .feed        (feed_if.issue),
    .tags        (tag_bus.pusher)
  );

  // weight rows and accumulate pipeline
  systolic_array u_systolic_array (
    .CLK     (CLK),
    .i_reset (i_reset),
    .feed    (feed_if.array),
    .res     (result_if.array)
  );

  // destination tags in flight
  gsau_tag_fifo u_gsau_tag_fifo (
    .CLK     (CLK),
    .i_reset (i_reset),
    .tags    (tag_bus.fifo)
  );

  // result plus tag toward the writeback buffer
  gsau_writeback u_gsau_writeback (
    .CLK        (CLK),
    .i_reset    (i_reset),
    .res        (result_if.sink),
    .tags       (tag_bus.popper),
    .i_wb_ready (i_wb_ready),
    .o_wb_valid (o_wb_valid),
    .o_wb_psum  (o_wb_psum),
    .o_wb_dst   (o_wb_dst)
  );

endmodule

/* testbench/gsau_sva.sv */
module gsau_sva (
  input logic                  CLK,
  input logic                  i_reset,
  input logic                  i_wb_ready,
  input logic                  o_wb_valid,
  input sa_cfg_pkg::psum_vec_t o_wb_psum,
  input gsau_cmd_pkg::tag_t    o_wb_dst,
  input logic                  push,
  input logic                  pop,
  input logic                  full,
  input logic                  empty
);

  int sva_errs = 0;

  // output register frozen while the writeback buffer stalls
  property hold_while_stalled;
    @(posedge CLK) disable iff (i_reset)
      (o_wb_valid && !i_wb_ready) |=> (o_wb_valid && $stable(o_wb_psum) && $stable(o_wb_dst));
  endproperty

  assert property (hold_while_stalled) else begin
    sva_errs++;
    $error("writeback output changed while stalled");
  end

  // tag fifo never overflows
  assert property (@(posedge CLK) disable iff (i_reset) !(push && full)) else begin
    sva_errs++;
    $error("tag push into a full fifo");
  end

  // nor underflows
  assert property (@(posedge CLK) disable iff (i_reset) !(pop && empty)) else begin
    sva_errs++;
    $error("tag pop from an empty fifo");
  end

endmodule

bind gsau_top gsau_sva u_gsau_sva (
  .CLK        (CLK),
  .i_reset    (i_reset),
  .i_wb_ready (i_wb_ready),
  .o_wb_valid (o_wb_valid),
  .o_wb_psum  (o_wb_psum),
  .o_wb_dst   (o_wb_dst),
  .push       (tag_bus.push),
  .pop        (tag_bus.pop),
  .full       (tag_bus.full),
  .empty      (tag_bus.empty)
);

/* testbench/gsau_tb.sv */
module gsau_tb;

  // wb_ready modes per table entry
  localparam logic [1:0] RDY_HIGH = 2'd0;
  localparam logic [1:0] RDY_RAND = 2'd1;
  // lone compute, drained first, latency measured
  localparam logic [1:0] LONE     = 2'd2;
  localparam int TIMEOUT  = 200;
  localparam int NUM_STIM = 25;

  typedef struct packed {
    logic [1:0]            mode;
    logic                  weight;
    gsau_cmd_pkg::tag_t    tag;
    sa_cfg_pkg::act_vec_t  vs1;
    sa_cfg_pkg::psum_vec_t vs2;
  } stim_t;

  // mode, weight flag, tag, vs1, vs2
  localparam stim_t STIM [NUM_STIM] = '{
    '{RDY_HIGH, 1'b1, 8'h00, 32'h04030201, 64'h0},
    '{RDY_HIGH, 1'b1, 8'h00, 32'h08070605, 64'h0},
    '{RDY_HIGH, 1'b1, 8'h00, 32'h0c0b0a09, 64'h0},
    '{RDY_HIGH, 1'b1, 8'h00, 32'h100f0e0d, 64'h0},
    '{RDY_HIGH, 1'b0, 8'h11, 32'h01010101, 64'h0},
    '{RDY_HIGH, 1'b0, 8'h12, 32'h04030201, 64'h0004_0003_0002_0001},
    '{RDY_HIGH, 1'b0, 8'h13, 32'h80402010, 64'h1000_2000_3000_4000},
    // weight behind computes still in flight
    '{RDY_HIGH, 1'b1, 8'h00, 32'hffffffff, 64'h0},
    '{RDY_HIGH, 1'b1, 8'h00, 32'hffffffff, 64'h0},
    '{RDY_HIGH, 1'b1, 8'h00, 32'hffffffff, 64'h0},
    '{RDY_HIGH, 1'b1, 8'h00, 32'hffffffff, 64'h0},
    // all 255, partial sums near the top, wraps
    '{RDY_HIGH, 1'b0, 8'h21, 32'hffffffff, 64'hfff0_ffff_8000_0001},
    '{LONE,     1'b0, 8'h22, 32'h01020304, 64'h0},
    '{RDY_RAND, 1'b1, 8'h00, 32'h13579bdf, 64'h0},
    '{RDY_RAND, 1'b1, 8'h00, 32'h2468ace0, 64'h0},
    '{RDY_RAND, 1'b1, 8'h00, 32'h0f1e2d3c, 64'h0},
    '{RDY_RAND, 1'b1, 8'h00, 32'hfedcba98, 64'h0},
    '{RDY_RAND, 1'b0, 8'h31, 32'hdeadbeef, 64'h0123_4567_89ab_cdef},
    '{RDY_RAND, 1'b0, 8'h32, 32'h00ff00ff, 64'hffff_0000_ffff_0000},
    '{RDY_RAND, 1'b0, 8'h33, 32'h12345678, 64'h0},
    '{RDY_RAND, 1'b0, 8'h34, 32'hffffffff, 64'hfffe_fffd_fffc_fffb},
    '{RDY_RAND, 1'b0, 8'h35, 32'ha5a5a5a5, 64'h1111_2222_3333_4444},
    '{RDY_RAND, 1'b1, 8'h00, 32'h55aa55aa, 64'h0},
    '{RDY_RAND, 1'b0, 8'h41, 32'h01010101, 64'h0},
    '{RDY_RAND, 1'b0, 8'h42, 32'h7f807f80, 64'h8000_8000_8000_8000}
  };

  logic                  CLK;
  logic                  i_reset;
  logic                  i_sb_valid;
  logic                  i_sb_weight;
  gsau_cmd_pkg::tag_t    i_sb_vdst;
  logic                  i_veg_valid;
  sa_cfg_pkg::act_vec_t  i_veg_vs1;
  sa_cfg_pkg::psum_vec_t i_veg_vs2;
  logic                  o_sb_ready;
  logic                  i_wb_ready;
  logic                  o_wb_valid;
  sa_cfg_pkg::psum_vec_t o_wb_psum;
  gsau_cmd_pkg::tag_t    o_wb_dst;

  // reference weight rows, row 0 newest
  sa_cfg_pkg::act_vec_t  model_w [sa_cfg_pkg::LANES];
  // expected results in issue order
  sa_cfg_pkg::psum_vec_t exp_psum_q [$];
  gsau_cmd_pkg::tag_t    exp_dst_q [$];

  logic [31:0] lfsr;
  logic        rnd_ready;
  int          data_errs;
  int          proto_errs;
  int          timeout_errs;

  gsau_top u_gsau_top (
    .CLK         (CLK),
    .i_reset     (i_reset),
    .i_sb_valid  (i_sb_valid),
    .i_sb_weight (i_sb_weight),
    .i_sb_vdst   (i_sb_vdst),
    .i_veg_valid (i_veg_valid),
    .i_veg_vs1   (i_veg_vs1),
    .i_veg_vs2   (i_veg_vs2),
    .o_sb_ready  (o_sb_ready),
    .i_wb_ready  (i_wb_ready),
    .o_wb_valid  (o_wb_valid),
    .o_wb_psum   (o_wb_psum),
    .o_wb_dst    (o_wb_dst)
  );

  always #2 CLK = ~CLK;

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // lane j = vs2[j] + sum over i of vs1[i] * row i [j], mod 2^16
  function automatic sa_cfg_pkg::psum_vec_t expect_psum(input sa_cfg_pkg::act_vec_t a,
                                                         input sa_cfg_pkg::psum_vec_t p);
    sa_cfg_pkg::psum_vec_t r;
    r = p;
    for (int i = 0; i < sa_cfg_pkg::LANES; i++) begin
      for (int j = 0; j < sa_cfg_pkg::LANES; j++) begin
        r[j] = r[j] + a[i] * model_w[i][j];
      end
    end
    return r;
  endfunction

  // closing summary and verdict
  task automatic finish_run();
    int sva_errs;
    sva_errs = u_gsau_top.u_gsau_sva.sva_errs;
    $display("errors: %0d value, %0d protocol, %0d timeout, %0d assertion",
             data_errs, proto_errs, timeout_errs, sva_errs);
    if (data_errs + proto_errs + timeout_errs + sva_errs == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  endtask

  // hold one entry until accepted at a rising edge
  task automatic apply_entry(input stim_t s);
    int waited;
    @(negedge CLK);
    i_sb_valid  = 1'b1;
    i_veg_valid = 1'b1;
    i_sb_weight = s.weight;
    i_sb_vdst   = s.tag;
    i_veg_vs1   = s.vs1;
    i_veg_vs2   = s.vs2;
    waited = 0;
    do begin
      @(posedge CLK);
      waited++;
    end while (!o_sb_ready && waited < TIMEOUT);
    if (!o_sb_ready) begin
      timeout_errs++;
      $display("command with tag %h not accepted within %0d cycles", s.tag, TIMEOUT);
    end
  endtask

  task automatic idle_inputs();
    @(negedge CLK);
    i_sb_valid  = 1'b0;
    i_veg_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (exp_psum_q.size() != 0 && cycles < TIMEOUT) begin
      @(negedge CLK);
      cycles++;
    end
    if (exp_psum_q.size() != 0) begin
      timeout_errs++;
      $display("%0d results still missing after %0d cycles", exp_psum_q.size(), TIMEOUT);
    end
  endtask

  // edges after the acceptance edge until o_wb_valid shows up
  task automatic check_latency();
    int edges;
    edges = 0;
    @(negedge CLK);
    i_sb_valid  = 1'b0;
    i_veg_valid = 1'b0;
    while (!o_wb_valid && edges < TIMEOUT) begin
      @(negedge CLK);
      edges++;
    end
    if (!o_wb_valid) begin
      timeout_errs++;
      $display("lone compute gave no result within %0d cycles", TIMEOUT);
    end else begin
      assert (edges == sa_cfg_pkg::LANES + 1) else begin
        proto_errs++;
        $display("ERROR t=%0t o_wb_valid latency got %0d expected %0d",
                 $time, edges, sa_cfg_pkg::LANES + 1);
      end
    end
  endtask

  // random or steady wb_ready, changed on the falling edge
  always @(negedge CLK) begin
    if (rnd_ready) begin
      lfsr = lfsr_step(lfsr);
      i_wb_ready = lfsr[0];
    end else begin
      i_wb_ready = 1'b1;
    end
  end

  // reference model on acceptance, then scoreboard on writeback
  always @(posedge CLK) begin
    if (!i_reset) begin
      if (i_sb_valid && i_veg_valid && o_sb_ready) begin
        if (i_sb_weight) begin
          // only the finished result in the output register may remain
          assert (exp_psum_q.size() == int'(o_wb_valid)) else begin
            proto_errs++;
            $display("weight load accepted at %0t while computes were still in the array",
                     $time);
          end
          for (int i = sa_cfg_pkg::LANES - 1; i > 0; i--) begin
            model_w[i] = model_w[i-1];
          end
          model_w[0] = i_veg_vs1;
        end else begin
          exp_psum_q.push_back(expect_psum(i_veg_vs1, i_veg_vs2));
          exp_dst_q.push_back(i_sb_vdst);
        end
      end
      if (o_wb_valid && i_wb_ready) begin
        if (exp_psum_q.size() == 0) begin
          proto_errs++;
          $display("result with tag %h at %0t was never issued", o_wb_dst, $time);
        end else begin
          assert (o_wb_psum == exp_psum_q[0]) else begin
            data_errs++;
            $display("ERROR t=%0t o_wb_psum got %h expected %h", $time, o_wb_psum,
                     exp_psum_q[0]);
          end
          assert (o_wb_dst == exp_dst_q[0]) else begin
            data_errs++;
            $display("ERROR t=%0t o_wb_dst got %h expected %h", $time, o_wb_dst, exp_dst_q[0]);
          end
          void'(exp_psum_q.pop_front());
          void'(exp_dst_q.pop_front());
        end
      end
    end
  end

  initial begin
    CLK          = 1'b0;
    i_reset      = 1'b1;
    i_sb_valid   = 1'b0;
    i_sb_weight  = 1'b0;
    i_sb_vdst    = '0;
    i_veg_valid  = 1'b0;
    i_veg_vs1    = '0;
    i_veg_vs2    = '0;
    i_wb_ready   = 1'b0;
    lfsr         = 32'h5f93;
    rnd_ready    = 1'b0;
    data_errs    = 0;
    proto_errs   = 0;
    timeout_errs = 0;
    for (int i = 0; i < sa_cfg_pkg::LANES; i++) begin
      model_w[i] = '0;
    end
    repeat (16) @(posedge CLK);
    @(negedge CLK);
    i_reset = 1'b0;
    // idle state before any command
    @(negedge CLK);
    assert (o_wb_valid == 1'b0) else begin
      proto_errs++;
      $display("ERROR t=%0t o_wb_valid got %b expected 0", $time, o_wb_valid);
    end
    assert (o_sb_ready == 1'b1) else begin
      proto_errs++;
      $display("ERROR t=%0t o_sb_ready got %b expected 1", $time, o_sb_ready);
    end
    for (int n = 0; n < NUM_STIM && timeout_errs == 0; n++) begin
      if (STIM[n].mode == LONE) begin
        rnd_ready = 1'b0;
        idle_inputs();
        wait_drain();
      end
      if (timeout_errs == 0) begin
        rnd_ready = (STIM[n].mode == RDY_RAND);
        apply_entry(STIM[n]);
      end
      if (timeout_errs == 0 && STIM[n].mode == LONE) begin
        check_latency();
        // lone result leaves before the ready mode changes
        @(posedge CLK);
      end
    end
    if (timeout_errs == 0) begin
      idle_inputs();
      wait_drain();
    end
    finish_run();
  end

endmodule

/* gsau.f */
design/sa_cfg_pkg.sv
design/gsau_cmd_pkg.sv
design/gsau_ifs.sv
design/gsau_issue.sv
design/systolic_array.sv
design/gsau_tag_fifo.sv
design/gsau_writeback.sv
design/gsau_top.sv
testbench/gsau_sva.sv
testbench/gsau_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= gsau_tb
FLIST     ?= gsau.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	-$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1
	cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --assert -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
